//--- Makefile
TOP ?= fetch_frontend_tb
LOG ?= sim.log
OBJ_DIR ?= obj_dir
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f verilog.f
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "=== PASS ===" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- branch_history_tables.sv
`include "fe_config.svh"

module branch_history_tables import fe_pkg::*; (
  input  logic         clk,
  input  logic         rst,
  input  fetch_addr_t  fetch_addr,
  input  ght_t         ght,
  input  retire_info_t retire,
  input  logic [3:0]   mispred_low,
  output logic         pred_taken
);

  localparam int NUM_TABLES = 3;
  localparam int TABLE_SIZE = 1 << `FE_TABLE_IDX_W;
  localparam int LINE_LSB   = $clog2(`FE_BUNDLE_BYTES);
  // A uses 2 history bits, B 4, C 6
  localparam int HIST_STEP  = 2;

  logic [TABLE_SIZE-1:0] tables [NUM_TABLES];
  table_idx_t            fetch_idx [NUM_TABLES];
  table_idx_t            retire_idx [NUM_TABLES];
  logic [NUM_TABLES-1:0] entry;
  logic [NUM_TABLES-1:0] toggle_en;
  logic                  update;

  // bundle address bits on top, low history bits below
  function automatic table_idx_t hash_idx(input fetch_addr_t addr, input ght_t hist,
                                          input int hist_bits);
    fetch_addr_t line;
    ght_t        hist_mask;
    line      = addr >> LINE_LSB;
    hist_mask = ght_t'((1 << hist_bits) - 1);
    return table_idx_t'((line << hist_bits) | fetch_addr_t'(hist & hist_mask));
  endfunction

  always_comb begin
    for (int t = 0; t < NUM_TABLES; t++) begin
      fetch_idx[t]  = hash_idx(fetch_addr, ght, HIST_STEP * (t + 1));
      retire_idx[t] = hash_idx(retire.src_ip, retire.ght, HIST_STEP * (t + 1));
      entry[t]      = tables[t][fetch_idx[t]];
    end
  end

  assign pred_taken = ^entry;

  // A every mispredict, B every 4th, C every 16th
  assign toggle_en[0] = 1'b1;
  assign toggle_en[1] = &mispred_low[1:0];
  assign toggle_en[2] = &mispred_low;

  assign update = retire.valid && retire.mispredict;

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int t = 0; t < NUM_TABLES; t++) begin
        tables[t] <= '0;
      end
    end else if (update) begin
      for (int t = 0; t < NUM_TABLES; t++) begin
        if (toggle_en[t]) begin
          tables[t][retire_idx[t]] <= ~tables[t][retire_idx[t]];
        end
      end
    end
  end

endmodule

//--- fe_config.svh
`ifndef FE_CONFIG_SVH
`define FE_CONFIG_SVH

// fetch address and history
`define FE_ADDR_W 32
`define FE_GHT_W 8

// bytes per fetch bundle, low address bits always zero
`define FE_BUNDLE_BYTES 16

// target buffer, 64 entries from addr[9:4], tag from addr[31:10]
`define FE_TBUF_IDX_W 6
`define FE_TBUF_TAG_W 22

// each prediction table has 2**8 one-bit entries
`define FE_TABLE_IDX_W 8

// register block
`define FE_CSR_ADDR_W 8
`define FE_CSR_CTRL 8'h00
`define FE_CSR_RESET_IP 8'h04
`define FE_CSR_CNT_TAKEN 8'h08
`define FE_CSR_CNT_MISS 8'h0C
`define FE_CSR_CNT_MISPRED 8'h10

`endif

//--- fe_csr.sv
`include "fe_config.svh"

module fe_csr import fe_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  csr_addr_t  awaddr,
  input  logic       awvalid,
  output logic       awready,
  input  csr_data_t  wdata,
  input  logic       wvalid,
  output logic       wready,
  output logic [1:0] bresp,
  output logic       bvalid,
  input  logic       bready,
  input  csr_addr_t  araddr,
  input  logic       arvalid,
  output logic       arready,
  output csr_data_t  rdata,
  output logic [1:0] rresp,
  output logic       rvalid,
  input  logic       rready,
  input  fe_events_t events,
  output fe_ctrl_t   ctrl
);

  localparam csr_data_t ALIGN_MASK = ~csr_data_t'(`FE_BUNDLE_BYTES - 1);

  csr_wr_state_t wr_state;
  csr_rd_state_t rd_state;
  logic          wr_fire;
  logic          rd_fire;
  logic          enable_q;
  logic          start_q;
  fetch_addr_t   reset_ip_q;
  event_count_t  cnt_taken;
  event_count_t  cnt_miss;
  event_count_t  cnt_mispred;
  csr_data_t     rd_word;
  csr_data_t     rdata_q;

  // address and data accepted together
  assign wr_fire = (wr_state == WR_IDLE) && awvalid && wvalid;
  assign awready = wr_fire;
  assign wready  = wr_fire;
  assign bvalid  = (wr_state == WR_RESP);
  assign bresp   = 2'b00;

  assign arready = (rd_state == RD_IDLE);
  assign rd_fire = arready && arvalid;
  assign rvalid  = (rd_state == RD_DATA);
  assign rresp   = 2'b00;
  assign rdata   = rdata_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_state <= WR_IDLE;
    end else begin
      case (wr_state)
        WR_IDLE: if (wr_fire) wr_state <= WR_RESP;
        WR_RESP: if (bready) wr_state <= WR_IDLE;
        default: wr_state <= WR_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_state <= RD_IDLE;
    end else begin
      case (rd_state)
        RD_IDLE: if (rd_fire) rd_state <= RD_DATA;
        RD_DATA: if (rready) rd_state <= RD_IDLE;
        default: rd_state <= RD_IDLE;
      endcase
    end
  end

  // start is a one-cycle pulse, counters and unmapped offsets ignore writes
  always_ff @(posedge clk) begin
    if (rst) begin
      enable_q   <= 1'b0;
      start_q    <= 1'b0;
      reset_ip_q <= '0;
    end else begin
      start_q <= 1'b0;
      if (wr_fire) begin
        case (awaddr)
          `FE_CSR_CTRL: begin
            enable_q <= wdata[0];
            start_q  <= wdata[1];
          end
          `FE_CSR_RESET_IP: reset_ip_q <= wdata & ALIGN_MASK;
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      cnt_taken   <= '0;
      cnt_miss    <= '0;
      cnt_mispred <= '0;
    end else begin
      cnt_taken   <= cnt_taken + event_count_t'(events.pred_taken);
      cnt_miss    <= cnt_miss + event_count_t'(events.tbuf_miss);
      cnt_mispred <= cnt_mispred + event_count_t'(events.mispredict);
    end
  end

  always_comb begin
    case (araddr)
      `FE_CSR_CTRL:        rd_word = csr_data_t'(enable_q);
      `FE_CSR_RESET_IP:    rd_word = reset_ip_q;
      `FE_CSR_CNT_TAKEN:   rd_word = cnt_taken;
      `FE_CSR_CNT_MISS:    rd_word = cnt_miss;
      `FE_CSR_CNT_MISPRED: rd_word = cnt_mispred;
      default:             rd_word = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rd_fire) rdata_q <= rd_word;
  end

  // pre-increment count, same cycle as the retirement it belongs to
  assign ctrl = '{enable: enable_q, start: start_q, reset_ip: reset_ip_q,
                  mispred_low: cnt_mispred[3:0]};

endmodule

//--- fe_pkg.sv
`include "fe_config.svh"

package fe_pkg;

  typedef logic [`FE_ADDR_W-1:0] fetch_addr_t;
  typedef logic [`FE_GHT_W-1:0] ght_t;
  typedef logic [`FE_TBUF_IDX_W-1:0] tbuf_idx_t;
  typedef logic [`FE_TBUF_TAG_W-1:0] tbuf_tag_t;
  typedef logic [`FE_TABLE_IDX_W-1:0] table_idx_t;
  typedef logic [`FE_CSR_ADDR_W-1:0] csr_addr_t;
  typedef logic [31:0] csr_data_t;
  typedef logic [31:0] event_count_t;

  // one retired branch, ght is the history it was predicted with
  typedef struct packed {
    logic        valid;
    logic        taken;
    logic        mispredict;
    fetch_addr_t src_ip;
    fetch_addr_t target;
    ght_t        ght;
  } retire_info_t;

  typedef struct packed {
    logic pred_taken;
    logic tbuf_miss;
    logic mispredict;
  } fe_events_t;

  // mispred_low drives the table B/C update cadence
  typedef struct packed {
    logic        enable;
    logic        start;
    fetch_addr_t reset_ip;
    logic [3:0]  mispred_low;
  } fe_ctrl_t;

  typedef enum logic {
    WR_IDLE,
    WR_RESP
  } csr_wr_state_t;

  typedef enum logic {
    RD_IDLE,
    RD_DATA
  } csr_rd_state_t;

endpackage

//--- fetch_frontend.sv
module fetch_frontend import fe_pkg::*; (
  input  logic         clk,
  input  logic         rst,
  input  csr_addr_t    awaddr,
  input  logic         awvalid,
  output logic         awready,
  input  csr_data_t    wdata,
  input  logic         wvalid,
  output logic         wready,
  output logic [1:0]   bresp,
  output logic         bvalid,
  input  logic         bready,
  input  csr_addr_t    araddr,
  input  logic         arvalid,
  output logic         arready,
  output csr_data_t    rdata,
  output logic [1:0]   rresp,
  output logic         rvalid,
  input  logic         rready,
  input  retire_info_t retire,
  input  logic         fetch_ready,
  output fetch_addr_t  fetch_addr,
  output logic         fetch_valid
);

  fe_ctrl_t    ctrl;
  fe_events_t  events;
  ght_t        ght;
  logic        pred_taken;
  logic        tbuf_hit;
  fetch_addr_t tbuf_target;

  fe_csr u_csr (
    .clk, .rst, .awaddr, .awvalid, .awready, .wdata, .wvalid, .wready, .bresp, .bvalid,
    .bready, .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready, .events, .ctrl
  );

  branch_history_tables u_tables (
    .clk, .rst, .fetch_addr, .ght, .retire, .mispred_low(ctrl.mispred_low), .pred_taken
  );

  target_buffer u_tbuf (
    .clk, .rst, .fetch_addr, .retire, .hit(tbuf_hit), .target(tbuf_target)
  );

  fetch_sequencer u_seq (
    .clk, .rst, .ctrl, .retire, .pred_taken, .tbuf_hit, .tbuf_target, .fetch_ready,
    .fetch_addr, .fetch_valid, .ght, .events
  );

endmodule

//--- fetch_frontend_asserts.sv
module fetch_frontend_asserts import fe_pkg::*; (
  input logic         clk,
  input logic         rst,
  input fetch_addr_t  fetch_addr,
  input logic         fetch_valid,
  input logic         fetch_ready,
  input retire_info_t retire,
  input fe_ctrl_t     ctrl,
  input logic         bvalid,
  input logic         bready,
  input logic         rvalid,
  input logic         rready
);

  // bundles are always 16-byte aligned
  a_align: assert property (@(posedge clk) disable iff (rst) fetch_addr[3:0] == 4'h0)
    else $error("fetch_addr not bundle aligned");

  a_hold: assert property (@(posedge clk) disable iff (rst)
    (fetch_valid && !fetch_ready && !(retire.valid && retire.mispredict) && !ctrl.start)
    |=> $stable(fetch_addr))
    else $error("fetch_addr moved during a stall");

  a_bvalid: assert property (@(posedge clk) disable iff (rst) (bvalid && !bready) |=> bvalid)
    else $error("bvalid dropped before bready");

  a_rvalid: assert property (@(posedge clk) disable iff (rst) (rvalid && !rready) |=> rvalid)
    else $error("rvalid dropped before rready");

endmodule

bind fetch_frontend fetch_frontend_asserts u_asserts (
  .clk(clk), .rst(rst), .fetch_addr(fetch_addr), .fetch_valid(fetch_valid),
  .fetch_ready(fetch_ready), .retire(retire), .ctrl(ctrl), .bvalid(bvalid),
  .bready(bready), .rvalid(rvalid), .rready(rready)
);

//--- fetch_frontend_tb.sv
`include "fe_config.svh"

module fetch_frontend_tb import fe_pkg::*; ();

  localparam int ROW_CYCLES = 400;

  typedef enum {K_WRITE, K_READ, K_READ_MODEL, K_RETIRE, K_FETCH, K_CHECK_ADDR} row_kind_t;

  typedef struct {
    row_kind_t kind;
    string     name;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] exp;
    ght_t        ght;
    bit          taken;
  } row_t;

  logic clk = 1'b0;
  logic rst = 1'b1;
  csr_addr_t awaddr = '0;
  logic awvalid = 1'b0;
  logic awready;
  csr_data_t wdata = '0;
  logic wvalid = 1'b0;
  logic wready;
  logic [1:0] bresp;
  logic bvalid;
  logic bready = 1'b0;
  csr_addr_t araddr = '0;
  logic arvalid = 1'b0;
  logic arready;
  csr_data_t rdata;
  logic [1:0] rresp;
  logic rvalid;
  logic rready = 1'b0;
  retire_info_t retire = '0;
  logic fetch_ready = 1'b0;
  fetch_addr_t fetch_addr;
  logic fetch_valid;

  row_t rows[$];
  bit   rows_built = 0;
  int   errors = 0;
  integer seed = 32'h994b_e295;

  // reference model state
  bit [255:0] m_tab_a, m_tab_b, m_tab_c;
  bit [63:0]  m_tv;
  logic [21:0] m_tag [64];
  logic [31:0] m_tgt [64];
  logic [31:0] m_addr, m_reset_ip, m_cnt_taken, m_cnt_miss, m_cnt_mis;
  ght_t m_ght;
  bit m_enable, m_start;

  fetch_frontend DUT (.*);

  always #2 clk = ~clk;

  function automatic logic [7:0] idx_a(logic [31:0] a, ght_t g);
    return {a[9:4], g[1:0]};
  endfunction

  function automatic logic [7:0] idx_b(logic [31:0] a, ght_t g);
    return {a[7:4], g[3:0]};
  endfunction

  function automatic logic [7:0] idx_c(logic [31:0] a, ght_t g);
    return {a[5:4], g[5:0]};
  endfunction

  function automatic logic [31:0] model_read(csr_addr_t a);
    case (a)
      `FE_CSR_CTRL:        return {31'b0, m_enable};
      `FE_CSR_RESET_IP:    return m_reset_ip;
      `FE_CSR_CNT_TAKEN:   return m_cnt_taken;
      `FE_CSR_CNT_MISS:    return m_cnt_miss;
      `FE_CSR_CNT_MISPRED: return m_cnt_mis;
      default:             return 32'h0;
    endcase
  endfunction

  // advance the model one clock on the inputs driven now
  task automatic step_model(input bit wr_fire, input csr_addr_t wa, input csr_data_t wd);
    bit redirect, accept, pred, hit, pok;
    logic [5:0] ri;
    redirect = retire.valid && retire.mispredict;
    accept = m_enable && fetch_ready;
    pred = m_tab_a[idx_a(m_addr, m_ght)] ^ m_tab_b[idx_b(m_addr, m_ght)] ^
           m_tab_c[idx_c(m_addr, m_ght)];
    ri = m_addr[9:4];
    hit = m_tv[ri] && (m_tag[ri] == m_addr[31:10]);
    pok = accept && !m_start && !redirect;
    if (redirect) begin
      m_tab_a[idx_a(retire.src_ip, retire.ght)] ^= 1'b1;
      if (m_cnt_mis[1:0] == 2'd3) m_tab_b[idx_b(retire.src_ip, retire.ght)] ^= 1'b1;
      if (m_cnt_mis[3:0] == 4'd15) m_tab_c[idx_c(retire.src_ip, retire.ght)] ^= 1'b1;
    end
    if (pok && pred && hit) m_cnt_taken++;
    if (pok && pred && !hit) m_cnt_miss++;
    if (redirect) m_cnt_mis++;
    if (m_start) begin
      m_addr = m_reset_ip;
      m_ght = '0;
    end else if (redirect) begin
      m_addr = {retire.target[31:4], 4'h0};
      m_ght = retire.ght;
    end else if (accept) begin
      m_addr = (pred && hit) ? {m_tgt[ri][31:4], 4'h0} : m_addr + 32'd16;
      m_ght = {m_ght[6:0], pred && hit};
    end
    // buffer written after the lookup of this cycle
    if (retire.valid && retire.taken) begin
      m_tv[retire.src_ip[9:4]] = 1'b1;
      m_tag[retire.src_ip[9:4]] = retire.src_ip[31:10];
      m_tgt[retire.src_ip[9:4]] = retire.target;
    end
    m_start = 1'b0;
    if (wr_fire && wa == `FE_CSR_CTRL) begin
      m_enable = wd[0];
      m_start = wd[1];
    end else if (wr_fire && wa == `FE_CSR_RESET_IP) begin
      m_reset_ip = {wd[31:4], 4'h0};
    end
  endtask

  // one clock with model update and a compare after the edge
  task automatic clock_cycle(input bit wr_fire, input csr_addr_t wa, input csr_data_t wd,
                             input string name);
    step_model(wr_fire, wa, wd);
    @(posedge clk);
    #1;
    if (fetch_addr !== m_addr) begin
      errors++;
      $display("CHECK FAILED %s fetch_addr expected %h actual %h", name, m_addr, fetch_addr);
    end
    if (fetch_valid !== m_enable) begin
      errors++;
      $display("CHECK FAILED %s fetch_valid expected %b actual %b", name, m_enable,
               fetch_valid);
    end
  endtask

  task automatic axi_write(input csr_addr_t a, input csr_data_t d, input string name);
    int guard;
    awaddr = a;
    wdata = d;
    awvalid = 1'b1;
    wvalid = 1'b1;
    guard = 0;
    #1;
    while (!(awready && wready) && guard < 50) begin
      clock_cycle(1'b0, '0, '0, name);
      #1;
      guard++;
    end
    if (guard >= 50) begin
      errors++;
      $display("%s: write address was never accepted", name);
    end
    clock_cycle(1'b1, a, d, name);
    awvalid = 1'b0;
    wvalid = 1'b0;
    guard = 0;
    #1;
    while (!bvalid && guard < 50) begin
      clock_cycle(1'b0, '0, '0, name);
      #1;
      guard++;
    end
    if (guard >= 50) begin
      errors++;
      $display("%s: write response never became valid", name);
    end
    // response has to wait for bready
    clock_cycle(1'b0, '0, '0, name);
    if (bvalid !== 1'b1) begin
      errors++;
      $display("CHECK FAILED %s bvalid expected 1 actual %b", name, bvalid);
    end
    bready = 1'b1;
    #1;
    if (bresp !== 2'b00) begin
      errors++;
      $display("CHECK FAILED %s bresp expected 0 actual %0d", name, bresp);
    end
    clock_cycle(1'b0, '0, '0, name);
    bready = 1'b0;
  endtask

  task automatic axi_read(input csr_addr_t a, input string name, output csr_data_t val,
                          output csr_data_t mval);
    int guard;
    araddr = a;
    arvalid = 1'b1;
    guard = 0;
    #1;
    while (!arready && guard < 50) begin
      clock_cycle(1'b0, '0, '0, name);
      #1;
      guard++;
    end
    if (guard >= 50) begin
      errors++;
      $display("%s: read address was never accepted", name);
    end
    mval = model_read(a);
    clock_cycle(1'b0, '0, '0, name);
    arvalid = 1'b0;
    guard = 0;
    #1;
    while (!rvalid && guard < 50) begin
      clock_cycle(1'b0, '0, '0, name);
      #1;
      guard++;
    end
    if (guard >= 50) begin
      errors++;
      $display("%s: read data never became valid", name);
    end
    val = rdata;
    // read data has to wait for rready
    clock_cycle(1'b0, '0, '0, name);
    if (rvalid !== 1'b1) begin
      errors++;
      $display("CHECK FAILED %s rvalid expected 1 actual %b", name, rvalid);
    end
    rready = 1'b1;
    #1;
    if (rresp !== 2'b00) begin
      errors++;
      $display("CHECK FAILED %s rresp expected 0 actual %0d", name, rresp);
    end
    clock_cycle(1'b0, '0, '0, name);
    rready = 1'b0;
  endtask

  task automatic add_row(input row_kind_t k, input string n, input logic [31:0] a,
                         input logic [31:0] d, input logic [31:0] e, input ght_t g,
                         input bit t);
    row_t r;
    r.kind = k;
    r.name = n;
    r.addr = a;
    r.data = d;
    r.exp = e;
    r.ght = g;
    r.taken = t;
    rows.push_back(r);
  endtask

  task automatic build_rows();
    add_row(K_READ, "reset_ctrl", `FE_CSR_CTRL, 0, 0, 0, 0);
    add_row(K_READ, "reset_ip", `FE_CSR_RESET_IP, 0, 0, 0, 0);
    add_row(K_READ, "reset_taken", `FE_CSR_CNT_TAKEN, 0, 0, 0, 0);
    add_row(K_READ, "reset_miss", `FE_CSR_CNT_MISS, 0, 0, 0, 0);
    add_row(K_READ, "reset_mispred", `FE_CSR_CNT_MISPRED, 0, 0, 0, 0);
    add_row(K_WRITE, "cnt_write", `FE_CSR_CNT_TAKEN, 32'h55, 0, 0, 0);
    add_row(K_READ, "cnt_after_write", `FE_CSR_CNT_TAKEN, 0, 0, 0, 0);
    add_row(K_READ, "unmapped", 8'h20, 0, 0, 0, 0);
    add_row(K_WRITE, "set_ip", `FE_CSR_RESET_IP, 32'h0000_100f, 0, 0, 0);
    add_row(K_READ, "ip_aligned", `FE_CSR_RESET_IP, 0, 32'h0000_1000, 0, 0);
    add_row(K_WRITE, "start", `FE_CSR_CTRL, 32'h3, 0, 0, 0);
    add_row(K_CHECK_ADDR, "at_reset_ip", 0, 0, 32'h0000_1000, 0, 0);
    add_row(K_FETCH, "seq_fetch", 0, 5, 0, 0, 0);
    add_row(K_CHECK_ADDR, "after_5", 0, 0, 32'h0000_1050, 0, 0);
    add_row(K_RETIRE, "stall_redirect", 32'h2000, 32'h3000, 0, 8'h5a, 0);
    add_row(K_CHECK_ADDR, "redirected", 0, 0, 32'h0000_3000, 0, 0);
    add_row(K_READ, "mispred_1", `FE_CSR_CNT_MISPRED, 0, 1, 0, 0);
    add_row(K_RETIRE, "taken_train", 32'h4040, 32'h4040, 0, 8'h00, 1);
    add_row(K_FETCH, "follow_target", 0, 4, 0, 0, 0);
    add_row(K_READ_MODEL, "taken_count", `FE_CSR_CNT_TAKEN, 0, 0, 0, 0);
    add_row(K_RETIRE, "alias_train", 32'h4440, 32'h4440, 0, 8'h33, 0);
    add_row(K_FETCH, "alias_fetch", 0, 2, 0, 0, 0);
    add_row(K_READ_MODEL, "miss_count", `FE_CSR_CNT_MISS, 0, 0, 0, 0);
    for (int i = 0; i < 16; i++) begin
      add_row(K_RETIRE, "cadence", 32'h8000 + i * 32'h50, 32'h8000 + ((i * 32'h90) & 32'hff0),
              0, ght_t'(i * 37), i[0]);
    end
    add_row(K_FETCH, "cadence_fetch", 0, 40, 0, 0, 0);
    add_row(K_READ_MODEL, "final_taken", `FE_CSR_CNT_TAKEN, 0, 0, 0, 0);
    add_row(K_READ_MODEL, "final_miss", `FE_CSR_CNT_MISS, 0, 0, 0, 0);
    add_row(K_READ_MODEL, "final_mispred", `FE_CSR_CNT_MISPRED, 0, 0, 0, 0);
  endtask

  initial begin
    wait (rows_built);
    #(rows.size() * ROW_CYCLES * 4 + 100);
    $display("timeout: the run did not finish in time");
    $display("=== FAIL ===");
    $finish;
  end

  initial begin
    csr_data_t val;
    csr_data_t mval;
    int accepted;
    m_tab_a = '0;
    m_tab_b = '0;
    m_tab_c = '0;
    m_tv = '0;
    m_addr = '0;
    m_reset_ip = '0;
    m_cnt_taken = '0;
    m_cnt_miss = '0;
    m_cnt_mis = '0;
    m_ght = '0;
    m_enable = 0;
    m_start = 0;
    build_rows();
    rows_built = 1;
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;
    foreach (rows[i]) begin
      case (rows[i].kind)
        K_WRITE: axi_write(rows[i].addr[7:0], rows[i].data, rows[i].name);
        K_READ, K_READ_MODEL: begin
          axi_read(rows[i].addr[7:0], rows[i].name, val, mval);
          if (rows[i].kind == K_READ) mval = rows[i].exp;
          if (val !== mval) begin
            errors++;
            $display("CHECK FAILED %s expected %h actual %h", rows[i].name, mval, val);
          end
        end
        K_RETIRE: begin
          // only the redirect moves a stalled fetch
          fetch_ready = 1'b0;
          retire = '{valid: 1'b1, taken: rows[i].taken, mispredict: 1'b1,
                     src_ip: rows[i].addr, target: rows[i].data, ght: rows[i].ght};
          clock_cycle(1'b0, '0, '0, rows[i].name);
          retire = '0;
        end
        K_FETCH: begin
          accepted = 0;
          while (accepted < rows[i].data) begin
            fetch_ready = $random(seed) & 1;
            if (fetch_ready && m_enable) accepted++;
            clock_cycle(1'b0, '0, '0, rows[i].name);
          end
          fetch_ready = 1'b0;
        end
        K_CHECK_ADDR: begin
          if (fetch_addr !== rows[i].exp) begin
            errors++;
            $display("CHECK FAILED %s expected %h actual %h", rows[i].name, rows[i].exp,
                     fetch_addr);
          end
        end
        default: ;
      endcase
    end
    $display("rows %0d, errors %0d", rows.size(), errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

//--- fetch_sequencer.sv
`include "fe_config.svh"

module fetch_sequencer import fe_pkg::*; (
  input  logic         clk,
  input  logic         rst,
  input  fe_ctrl_t     ctrl,
  input  retire_info_t retire,
  input  logic         pred_taken,
  input  logic         tbuf_hit,
  input  fetch_addr_t  tbuf_target,
  input  logic         fetch_ready,
  output fetch_addr_t  fetch_addr,
  output logic         fetch_valid,
  output ght_t         ght,
  output fe_events_t   events
);

  localparam fetch_addr_t STEP       = fetch_addr_t'(`FE_BUNDLE_BYTES);
  localparam fetch_addr_t ALIGN_MASK = ~fetch_addr_t'(`FE_BUNDLE_BYTES - 1);

  fetch_addr_t addr_q;
  ght_t        ght_q;
  logic        redirect;
  logic        accept;
  logic        follow;
  logic        predict_ok;

  assign fetch_valid = ctrl.enable;
  assign accept      = fetch_valid && fetch_ready;
  assign redirect    = retire.valid && retire.mispredict;

  // sequential fetch unless start or a mispredict wins
  assign predict_ok = accept && !ctrl.start && !redirect;
  assign follow     = pred_taken && tbuf_hit;

  always_ff @(posedge clk) begin
    if (rst) begin
      addr_q <= '0;
      ght_q  <= '0;
    end else if (ctrl.start) begin
      addr_q <= ctrl.reset_ip;
      ght_q  <= '0;
    end else if (redirect) begin
      // restore history even while stalled
      addr_q <= retire.target & ALIGN_MASK;
      ght_q  <= retire.ght;
    end else if (accept) begin
      if (follow) begin
        addr_q <= tbuf_target & ALIGN_MASK;
        ght_q  <= {ght_q[`FE_GHT_W-2:0], 1'b1};
      end else begin
        // taken with a buffer miss falls through too
        addr_q <= addr_q + STEP;
        ght_q  <= {ght_q[`FE_GHT_W-2:0], 1'b0};
      end
    end
  end

  assign fetch_addr = addr_q;
  assign ght        = ght_q;

  assign events.pred_taken = predict_ok && follow;
  assign events.tbuf_miss  = predict_ok && pred_taken && !tbuf_hit;
  assign events.mispredict = redirect;

endmodule

//--- target_buffer.sv
`include "fe_config.svh"

module target_buffer import fe_pkg::*; (
  input  logic         clk,
  input  logic         rst,
  input  fetch_addr_t  fetch_addr,
  input  retire_info_t retire,
  output logic         hit,
  output fetch_addr_t  target
);

  localparam int ENTRIES  = 1 << `FE_TBUF_IDX_W;
  localparam int LINE_LSB = $clog2(`FE_BUNDLE_BYTES);
  localparam int TAG_LSB  = LINE_LSB + `FE_TBUF_IDX_W;

  logic [ENTRIES-1:0] valid_q;
  tbuf_tag_t          tag_q [ENTRIES];
  fetch_addr_t        target_q [ENTRIES];
  tbuf_idx_t          rd_idx;
  tbuf_tag_t          rd_tag;
  tbuf_idx_t          wr_idx;
  tbuf_tag_t          wr_tag;
  logic               wr_en;

  assign rd_idx = fetch_addr[LINE_LSB +: `FE_TBUF_IDX_W];
  assign rd_tag = fetch_addr[TAG_LSB +: `FE_TBUF_TAG_W];
  assign wr_idx = retire.src_ip[LINE_LSB +: `FE_TBUF_IDX_W];
  assign wr_tag = retire.src_ip[TAG_LSB +: `FE_TBUF_TAG_W];
  assign wr_en  = retire.valid && retire.taken;

  // lookup at the current fetch address
  assign hit    = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
  assign target = target_q[rd_idx];

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else if (wr_en) begin
      valid_q[wr_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      tag_q[wr_idx]    <= wr_tag;
      target_q[wr_idx] <= retire.target;
    end
  end

endmodule

//--- verilog.f
+incdir+.
fe_pkg.sv
fe_csr.sv
branch_history_tables.sv
target_buffer.sv
fetch_sequencer.sv
fetch_frontend.sv
fetch_frontend_asserts.sv
fetch_frontend_tb.sv
